/* hdl/axis_out_shift.sv */
`default_nettype none

module axis_out_shift (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                s_valid,
  input  logic                                s_last,
  input  logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] s_data,
  input  logic [out_stream_pkg::KW2_BITS-1:0] s_kw2,
  input  logic                                s_is_w_first_kw2,
  input  logic                                s_is_w_last,
  input  logic                                s_is_config,
  output logic                                s_ready,
  input  logic                                m_ready,
  output logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] m_data,
  output logic                                m_valid,
  output logic                                m_last,
  output logic                                m_last_pkt
);

  // Column c sits at index COLS-c, so column 1 leaves first.
  logic [out_geom_pkg::KW_MAX/2:0][out_geom_pkg::COLS-1:0] lut_valid;
  logic [out_geom_pkg::KW_MAX/2:0][out_geom_pkg::COLS-1:0] lut_valid_last;
  logic [out_geom_pkg::KW_MAX/2:0][out_geom_pkg::COLS-1:0] lut_last;
  logic [out_geom_pkg::KW_MAX/2:0][out_geom_pkg::COLS-1:0] lut_last_pkt;

  logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] s_data_rev;
  logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] shift_data;
  logic [out_geom_pkg::COLS-1:0] shift_valid;
  logic [out_geom_pkg::COLS-1:0] shift_last;
  logic [out_geom_pkg::COLS-1:0] shift_last_pkt;
  logic [out_geom_pkg::COLS-1:0] sel_valid;
  logic [out_geom_pkg::COLS-1:0] sel_last;
  logic [out_geom_pkg::CNT_BITS-1:0] cnt;
  logic shift_st; // High in SHIFT.
  logic keep;
  logic load;

  for (genvar kw = 0; kw <= out_geom_pkg::KW_MAX / 2; kw++) begin : g_kw
    for (genvar col = 1; col <= out_geom_pkg::COLS; col++) begin : g_col
      assign lut_valid[kw][out_geom_pkg::COLS-col] = (col % (2*kw+1) == 0);
      assign lut_valid_last[kw][out_geom_pkg::COLS-col] =
        (col <= (out_geom_pkg::COLS / (2*kw+1)) * (2*kw+1)) &&
        ((col % (2*kw+1) == 0) || (col % (2*kw+1) > kw));
      assign lut_last[kw][out_geom_pkg::COLS-col]     = (col == 2*kw+1);
      assign lut_last_pkt[kw][out_geom_pkg::COLS-col] = (col == kw+1);
    end
  end

  for (genvar col = 1; col <= out_geom_pkg::COLS; col++) begin : g_rev
    assign s_data_rev[out_geom_pkg::COLS-col] = s_data[col-1];
  end

  assign keep = !s_is_w_first_kw2 && !s_is_config;
  assign load = s_valid && !shift_st && keep;

  assign sel_valid = s_is_w_last ? lut_valid_last[s_kw2] : lut_valid[s_kw2];
  assign sel_last  = s_is_w_last ? lut_last_pkt[s_kw2]   : lut_last[s_kw2];

  assign s_ready = !shift_st;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      shift_st       <= 1'b0;
      cnt            <= out_geom_pkg::CNT_BITS'(out_geom_pkg::COLS);
      shift_valid    <= '0;
      shift_last     <= '0;
      shift_last_pkt <= '0;
    end else if (!shift_st) begin
      if (load) begin
        shift_st       <= 1'b1;
        shift_valid    <= sel_valid;
        shift_last     <= sel_last;
        shift_last_pkt <= lut_last_pkt[s_kw2] & {out_geom_pkg::COLS{s_last}};
      end
    end else if (m_ready) begin
      shift_valid    <= shift_valid << 1; // Empty slots fill with zero.
      shift_last     <= shift_last << 1;
      shift_last_pkt <= shift_last_pkt << 1;
      if (cnt == 1) begin
        shift_st <= 1'b0;
        cnt      <= out_geom_pkg::CNT_BITS'(out_geom_pkg::COLS);
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      shift_data <= s_data_rev;
    end else if (shift_st && m_ready) begin
      shift_data <= shift_data << (out_geom_pkg::ROWS * out_geom_pkg::Y_BITS);
    end
  end

  assign m_data     = shift_data[out_geom_pkg::COLS-1];
  assign m_valid    = shift_valid[out_geom_pkg::COLS-1];
  assign m_last     = shift_last[out_geom_pkg::COLS-1];
  assign m_last_pkt = shift_last_pkt[out_geom_pkg::COLS-1];

endmodule

`default_nettype wire

/* hdl/out_clip.sv */
`default_nettype none

module out_clip (
  input  logic                                                      aclk,
  input  logic                                                      aresetn,
  input  logic                                                      s_valid,
  input  logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0]   s_data,
  input  logic                                                      s_last,
  input  logic                                                      s_last_pkt,
  output logic                                                      s_ready,
  input  logic                                                      m_ready,
  output logic                                                      m_valid,
  output logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::OUT_BITS-1:0] m_data,
  output logic                                                      m_last,
  output logic                                                      m_last_pkt
);

  logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::OUT_BITS-1:0] clip_d;

  // ReLU, then saturate to the output range.
  function automatic logic [out_geom_pkg::OUT_BITS-1:0] clip_word(
    input logic [out_geom_pkg::Y_BITS-1:0] w
  );
    if (w[out_geom_pkg::Y_BITS-1]) begin
      return '0;
    end
    if (|w[out_geom_pkg::Y_BITS-2:out_geom_pkg::OUT_BITS]) begin
      return '1;
    end
    return w[out_geom_pkg::OUT_BITS-1:0];
  endfunction

  for (genvar r = 0; r < out_geom_pkg::ROWS; r++) begin : g_row
    assign clip_d[r] = clip_word(s_data[r]);
  end

  // Register takes a new word when empty or draining.
  assign s_ready = !m_valid || m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      m_valid    <= 1'b0;
      m_last     <= 1'b0;
      m_last_pkt <= 1'b0;
    end else if (s_ready) begin
      m_valid    <= s_valid;
      m_last     <= s_valid && s_last;
      m_last_pkt <= s_valid && s_last_pkt;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_ready && s_valid) begin
      m_data <= clip_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/out_geom_pkg.sv */
`default_nettype none

package out_geom_pkg;

  // Words per array column.
  localparam int ROWS = 4;

  // Columns per array beat.
  localparam int COLS = 6;

  // Largest odd kernel width.
  localparam int KW_MAX = 5;

  // Signed accumulator word.
  localparam int Y_BITS = 16;

  // Unsigned output word.
  localparam int OUT_BITS = 8;

  // Column counter, holds COLS.
  localparam int CNT_BITS = $clog2(COLS + 1);

endpackage

`default_nettype wire

/* hdl/out_stage_top.sv */
`default_nettype none

module out_stage_top (
  input  logic                                                      aclk,
  input  logic                                                      aresetn,
  input  logic                                                      s_valid,
  input  out_stream_pkg::in_word_u                                  s_data,
  input  logic                                                      s_cfg,
  input  logic                                                      s_last,
  output logic                                                      s_ready,
  output logic                                                      m_valid,
  output logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::OUT_BITS-1:0] m_data,
  output logic                                                      m_last,
  output logic                                                      m_last_pkt,
  input  logic                                                      m_ready
);

  logic b_valid;
  logic b_ready;
  logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] b_data;
  logic b_last;
  logic [out_stream_pkg::KW2_BITS-1:0] b_kw2;
  logic b_is_w_first_kw2;
  logic b_is_w_last;
  logic b_is_config;

  logic c_valid;
  logic c_ready;
  logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] c_data;
  logic c_last;
  logic c_last_pkt;

  out_user_seq seq_i (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .s_valid          (s_valid),
    .s_data           (s_data),
    .s_cfg            (s_cfg),
    .s_last           (s_last),
    .s_ready          (s_ready),
    .b_ready          (b_ready),
    .b_valid          (b_valid),
    .b_data           (b_data),
    .b_last           (b_last),
    .b_kw2            (b_kw2),
    .b_is_w_first_kw2 (b_is_w_first_kw2),
    .b_is_w_last      (b_is_w_last),
    .b_is_config      (b_is_config)
  );

  // One column per cycle.
  axis_out_shift shift_i (
    .aclk             (aclk),
    .aresetn          (aresetn),
    .s_valid          (b_valid),
    .s_last           (b_last),
    .s_data           (b_data),
    .s_kw2            (b_kw2),
    .s_is_w_first_kw2 (b_is_w_first_kw2),
    .s_is_w_last      (b_is_w_last),
    .s_is_config      (b_is_config),
    .s_ready          (b_ready),
    .m_ready          (c_ready),
    .m_data           (c_data),
    .m_valid          (c_valid),
    .m_last           (c_last),
    .m_last_pkt       (c_last_pkt)
  );

  out_clip clip_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_valid    (c_valid),
    .s_data     (c_data),
    .s_last     (c_last),
    .s_last_pkt (c_last_pkt),
    .s_ready    (c_ready),
    .m_ready    (m_ready),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_last     (m_last),
    .m_last_pkt (m_last_pkt)
  );

endmodule

`default_nettype wire

/* hdl/out_stream_pkg.sv */
`default_nettype none

package out_stream_pkg;

  // kw2 = floor(k/2), 0 to KW_MAX/2.
  localparam int KW2_BITS = $clog2(out_geom_pkg::KW_MAX / 2 + 1);

  // Beats per weight pass.
  localparam int WCNT_BITS = 8;

  localparam int IN_BITS = out_geom_pkg::COLS * out_geom_pkg::ROWS * out_geom_pkg::Y_BITS;

  localparam int RSVD_BITS = IN_BITS - WCNT_BITS - KW2_BITS;

  // One input word, read as results or as layer configuration.
  typedef union packed {
    // Two's complement words, column c at index c-1.
    logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] res;
    struct packed {
      logic [RSVD_BITS-1:0] rsvd;
      logic [WCNT_BITS-1:0] w_count;
      logic [KW2_BITS-1:0]  kw2;
    } cfg;
  } in_word_u;

endpackage

`default_nettype wire

/* hdl/out_user_seq.sv */
`default_nettype none

module out_user_seq (
  input  logic                                  aclk,
  input  logic                                  aresetn,
  input  logic                                  s_valid,
  input  out_stream_pkg::in_word_u              s_data,
  input  logic                                  s_cfg,
  input  logic                                  s_last,
  output logic                                  s_ready,
  input  logic                                  b_ready,
  output logic                                  b_valid,
  output logic [out_geom_pkg::COLS-1:0][out_geom_pkg::ROWS-1:0][out_geom_pkg::Y_BITS-1:0] b_data,
  output logic                                  b_last,
  output logic [out_stream_pkg::KW2_BITS-1:0]   b_kw2,
  output logic                                  b_is_w_first_kw2,
  output logic                                  b_is_w_last,
  output logic                                  b_is_config
);

  logic [out_stream_pkg::KW2_BITS-1:0]  kw2_q;
  logic [out_stream_pkg::WCNT_BITS-1:0] w_count_q;
  logic [out_stream_pkg::WCNT_BITS-1:0] w_q;
  logic [out_stream_pkg::WCNT_BITS-1:0] kw2_ext;
  logic [out_stream_pkg::WCNT_BITS-1:0] w_last_idx;
  logic                                 xfer;
  logic                                 at_last;

  assign xfer = s_valid && b_ready;

  assign kw2_ext    = {{(out_stream_pkg::WCNT_BITS - out_stream_pkg::KW2_BITS){1'b0}}, kw2_q};
  assign w_last_idx = w_count_q - 1'b1;
  assign at_last    = (w_q == w_last_idx);

  // Data path is pure pass-through.
  assign s_ready = b_ready;
  assign b_valid = s_valid;
  assign b_data  = s_data.res;
  assign b_last  = s_last;
  assign b_kw2   = kw2_q;

  assign b_is_config      = s_cfg;
  assign b_is_w_first_kw2 = !s_cfg && (w_q < kw2_ext); // Warm-up beat.
  assign b_is_w_last      = !s_cfg && at_last;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      kw2_q     <= '0;
      w_count_q <= out_stream_pkg::WCNT_BITS'(1);
      w_q       <= '0;
    end else if (xfer) begin
      if (s_cfg) begin
        kw2_q     <= s_data.cfg.kw2;
        w_count_q <= s_data.cfg.w_count;
        w_q       <= '0; // New layer restarts the pass.
      end else if (at_last) begin
        w_q <= '0;
      end else begin
        w_q <= w_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* list.f */
hdl/out_geom_pkg.sv
hdl/out_stream_pkg.sv
hdl/out_user_seq.sv
hdl/axis_out_shift.sv
hdl/out_clip.sv
hdl/out_stage_top.sv
test/tb_out_stage.sv

/* test/tb_out_stage.sv */
`default_nettype none

module tb_out_stage;

  logic aclk;
  logic aresetn;
  logic s_valid;
  out_stream_pkg::in_word_u s_data;
  logic s_cfg;
  logic s_last;
  logic s_ready;
  logic m_valid;
  logic [out_geom_pkg::ROWS-1:0][out_geom_pkg::OUT_BITS-1:0] m_data;
  logic m_last;
  logic m_last_pkt;
  logic m_ready;

  // Expected column as {last_pkt, last, data}.
  logic [out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS+1:0] exp_q[$];
  logic [out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS+1:0] exp_word;

  int m_kw2;
  int m_wc;
  int m_w;
  int busy_left;
  int errs;
  int checks;
  int tests;
  int errs_before;
  bit bp_mode;

  out_stage_top dut_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_valid    (s_valid),
    .s_data     (s_data),
    .s_cfg      (s_cfg),
    .s_last     (s_last),
    .s_ready    (s_ready),
    .m_valid    (m_valid),
    .m_data     (m_data),
    .m_last     (m_last),
    .m_last_pkt (m_last_pkt),
    .m_ready    (m_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errs++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("*** FAILED ***");
    $finish;
  endtask

  function automatic logic [out_geom_pkg::OUT_BITS-1:0] clip_ref(
    input logic signed [out_geom_pkg::Y_BITS-1:0] x
  );
    if (x < 0) begin
      return '0;
    end
    if (x > (1 << out_geom_pkg::OUT_BITS) - 1) begin
      return '1;
    end
    return x[out_geom_pkg::OUT_BITS-1:0];
  endfunction

  // Returns 1 when the beat is shifted out.
  function automatic bit expect_beat(input out_stream_pkg::in_word_u d, input bit cfg,
                                     input bit last);
    logic [out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS-1:0] col_word;
    bit first;
    bit wlast;
    bit v;
    bit l;
    int k;
    if (cfg) begin
      m_kw2 = d.cfg.kw2;
      m_wc  = d.cfg.w_count;
      m_w   = 0;
      return 1'b0;
    end
    first = (m_w < m_kw2);
    wlast = (m_w == m_wc - 1);
    m_w   = wlast ? 0 : m_w + 1;
    if (first) begin
      return 1'b0; // Warm-up beat.
    end
    k = 2 * m_kw2 + 1;
    for (int c = 1; c <= out_geom_pkg::COLS; c++) begin
      if (wlast) begin
        v = (c <= (out_geom_pkg::COLS / k) * k) && ((c % k == 0) || (c % k > m_kw2));
        l = (c == m_kw2 + 1);
      end else begin
        v = (c % k == 0);
        l = (c == k);
      end
      for (int r = 0; r < out_geom_pkg::ROWS; r++) begin
        col_word[r*out_geom_pkg::OUT_BITS +: out_geom_pkg::OUT_BITS] = clip_ref(d.res[c-1][r]);
      end
      if (v) begin
        exp_q.push_back({last && (c == m_kw2 + 1), l, col_word});
      end
    end
    return 1'b1;
  endfunction

  function automatic logic [out_geom_pkg::Y_BITS-1:0] pick_word(input bit extreme);
    logic [out_geom_pkg::Y_BITS-1:0] w;
    w = $urandom;
    if (extreme) begin
      case ($urandom % 7)
        0: w = {1'b1, {(out_geom_pkg::Y_BITS-1){1'b0}}}; // Most negative.
        1: w = {1'b0, {(out_geom_pkg::Y_BITS-1){1'b1}}};
        2: w = '1;
        3: w = '0;
        4: w = (1 << out_geom_pkg::OUT_BITS) - 1;
        5: w = 1 << out_geom_pkg::OUT_BITS;
        default: w = $urandom % 512;
      endcase
    end
    return w;
  endfunction

  function automatic out_stream_pkg::in_word_u make_beat(input bit extreme);
    out_stream_pkg::in_word_u d;
    for (int c = 0; c < out_geom_pkg::COLS; c++) begin
      for (int r = 0; r < out_geom_pkg::ROWS; r++) begin
        d.res[c][r] = pick_word(extreme);
      end
    end
    return d;
  endfunction

  function automatic out_stream_pkg::in_word_u make_cfg(input int kw2, input int wc);
    out_stream_pkg::in_word_u d;
    d = make_beat(1'b0); // Reserved bits stay random.
    d.cfg.kw2     = kw2;
    d.cfg.w_count = wc;
    return d;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic send_beat(input out_stream_pkg::in_word_u d, input bit cfg, input bit last);
    int waited;
    waited  = 0;
    s_data  = d;
    s_cfg   = cfg;
    s_last  = last;
    s_valid = 1'b1;
    while (!s_ready) begin
      waited++;
      if (waited > 200) begin
        abort_run("input beat was not accepted within 200 cycles");
      end
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);
    #1;
    s_valid = 1'b0;
    s_cfg   = 1'b0;
    s_last  = 1'b0;
  endtask

  task automatic send_pass(input int n, input bit extreme, input int last_pct);
    for (int i = 0; i < n; i++) begin
      if (bp_mode) begin
        idle_cycles($urandom % 3);
      end
      send_beat(make_beat(extreme), 1'b0, ($urandom % 100) < last_pct);
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || !s_ready || m_valid) begin
      waited++;
      if (waited > 2000) begin
        abort_run("output stream did not drain within 2000 cycles");
      end
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s: %s", tests, name, (errs == errs_before) ? "ok" : "mismatch");
    errs_before = errs;
  endtask

  // Input side model and busy check.
  always @(posedge aclk) begin
    if (!aresetn) begin
      m_kw2     = 0;
      m_wc      = 1;
      m_w       = 0;
      busy_left = 0;
    end else begin
      if (busy_left > 0) begin
        check_val("s_ready", 0, s_ready);
        busy_left--;
      end
      if (s_valid && s_ready) begin
        if (expect_beat(s_data, s_cfg, s_last)) begin
          busy_left = out_geom_pkg::COLS;
        end
      end
    end
  end

  always @(posedge aclk) begin
    if (aresetn && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        errs++;
        $display("Error at %0t: output word arrived with none expected", $time);
      end else begin
        exp_word = exp_q.pop_front();
        check_val("m_data", exp_word[out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS-1:0], m_data);
        check_val("m_last", exp_word[out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS], m_last);
        check_val("m_last_pkt", exp_word[out_geom_pkg::ROWS*out_geom_pkg::OUT_BITS+1],
                  m_last_pkt);
      end
    end
  end

  always @(posedge aclk) begin
    #1;
    if (bp_mode) begin
      m_ready = ($urandom % 4) != 0;
    end else begin
      m_ready = 1'b1;
    end
  end

  initial begin
    void'($urandom(33));
    aresetn     = 1'b0;
    s_valid     = 1'b0;
    s_data      = '0;
    s_cfg       = 1'b0;
    s_last      = 1'b0;
    m_ready     = 1'b1;
    bp_mode     = 1'b0;
    errs        = 0;
    checks      = 0;
    tests       = 0;
    errs_before = 0;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    check_val("s_ready", 1, s_ready);
    check_val("m_valid", 0, m_valid);
    repeat (8) begin
      @(posedge aclk);
      #1;
      check_val("m_valid", 0, m_valid);
    end
    finish_test("reset");

    send_beat(make_cfg(0, 3), 1'b1, 1'b0);
    send_pass(6, 1'b0, 0);
    wait_idle();
    finish_test("kernel width 1");

    for (int kw = 1; kw <= out_geom_pkg::KW_MAX / 2; kw++) begin
      send_beat(make_cfg(kw, 4), 1'b1, 1'b0);
      send_pass(8, 1'b0, 0);
    end
    wait_idle();
    finish_test("kernel widths 3 and 5");

    for (int kw = 0; kw <= out_geom_pkg::KW_MAX / 2; kw++) begin
      send_beat(make_cfg(kw, 3), 1'b1, 1'b0);
      send_pass(6, 1'b0, 50);
    end
    wait_idle();
    finish_test("packet end");

    send_beat(make_cfg(0, 2), 1'b1, 1'b0);
    send_pass(10, 1'b1, 0);
    send_beat(make_cfg(1, 3), 1'b1, 1'b0);
    send_pass(6, 1'b1, 0);
    wait_idle();
    finish_test("clipping");

    bp_mode = 1'b1;
    for (int i = 0; i < 300; i++) begin
      if (i % 40 == 0) begin
        send_beat(make_cfg($urandom % (out_geom_pkg::KW_MAX / 2 + 1), 1 + $urandom % 6),
                  1'b1, 1'b0);
      end
      send_pass(1, i[0], 30);
    end
    bp_mode = 1'b0;
    wait_idle();
    finish_test("back-pressure");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errs);
    if (errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
